// File: degu_bus_pkg.sv
package degu_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // bytes per word and byte offset bits
  localparam int unsigned BLEN = XLEN/8;
  localparam int unsigned BLOG = $clog2(BLEN);

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  // memory 0x0000-0x3fff, peripherals 0x4000-0x7fff, above is unmapped
  localparam int unsigned PER_BIT = 14;
  // inside peripheral window, clear selects GPIO, set was the UART
  localparam int unsigned GPIO_BIT = 6;

  // GPIO register word offsets
  localparam int unsigned GPIO_OUT_OFS = 0;
  localparam int unsigned GPIO_ENA_OFS = 1;
  localparam int unsigned GPIO_INP_OFS = 2;

  ////////////////////////////////////////////////////////////////////////////
  // bus payloads
  ////////////////////////////////////////////////////////////////////////////

  // request, 69 bits
  typedef struct packed {
    logic            wen;  // write enable
    logic [XLEN-1:0] adr;  // byte address
    logic [BLEN-1:0] ben;  // byte enables
    logic [XLEN-1:0] wdt;  // write data
  } bus_req_t;

  // response, 33 bits
  typedef struct packed {
    logic [XLEN-1:0] rdt;  // read data
    logic            err;  // error
  } bus_rsp_t;

  // one-hot target select
  typedef struct packed {
    logic mem;
    logic gpio;
    logic none;
  } tgt_sel_t;

endpackage: degu_bus_pkg

// File: lsu_decoder.sv
`timescale 1ns/10ps

module lsu_decoder (
  // request from the bus master
  input  degu_bus_pkg::bus_req_t req,
  input  logic                   req_vld,
  // target select
  output degu_bus_pkg::tgt_sel_t tgt_sel,
  // per target request valid
  output logic                   mem_vld,
  output logic                   gpio_vld
);

  import degu_bus_pkg::*;

////////////////////////////////////////////////////////////////////////////
// address classification
////////////////////////////////////////////////////////////////////////////

  // any bit above the peripheral window
  logic adr_high;
  // peripheral window bit
  logic adr_per;
  // UART window inside peripherals
  logic adr_uart;

  assign adr_high = |req.adr[XLEN-1:PER_BIT+1];
  assign adr_per  = req.adr[PER_BIT];
  assign adr_uart = req.adr[GPIO_BIT];

  // exactly one select bit is set
  always_comb begin
    tgt_sel = '0;
    if (adr_high) begin
      tgt_sel.none = 1'b1;
    end else if (!adr_per) begin
      tgt_sel.mem = 1'b1;
    end else if (!adr_uart) begin
      tgt_sel.gpio = 1'b1;
    end else begin
      // former UART window, nothing answers
      tgt_sel.none = 1'b1;
    end
  end

////////////////////////////////////////////////////////////////////////////
// valid steering
////////////////////////////////////////////////////////////////////////////

  // unmapped requests reach no target
  assign mem_vld  = req_vld & tgt_sel.mem;
  assign gpio_vld = req_vld & tgt_sel.gpio;

endmodule: lsu_decoder

// File: data_memory.sv
`timescale 1ns/10ps

module data_memory #(
  // word address bits
  parameter int unsigned MEM_ADR = 12
)(
  input  logic                   clk,
  input  logic                   reset,
  // request
  input  logic                   vld,
  input  degu_bus_pkg::bus_req_t req,
  // response, one cycle later
  output degu_bus_pkg::bus_rsp_t rsp
);

  import degu_bus_pkg::*;

  // storage array, contents undefined until written
  logic [XLEN-1:0] mem [0:2**MEM_ADR-1];

  // word index above the byte offset
  logic [MEM_ADR-1:0] idx;
  // read data register
  logic [XLEN-1:0]    rdt;
  // load in flight
  logic               ld;

  // upper address bits alias when the memory is small
  assign idx = req.adr[MEM_ADR+BLOG-1:BLOG];

  // byte enabled write
  always_ff @(posedge clk) begin
    if (vld && req.wen) begin
      for (int b = 0; b < BLEN; b++) begin
        if (req.ben[b]) mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
      end
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    if (vld && !req.wen) rdt <= mem[idx];
  end

  // marks whether the response carries read data
  always_ff @(posedge clk) begin
    if (reset) ld <= 1'b0;
    else       ld <= vld & ~req.wen;
  end

  // stores return zero, memory never errors
  assign rsp = '{rdt: ld ? rdt : '0, err: 1'b0};

endmodule: data_memory

// File: gpio_controller.sv
`timescale 1ns/10ps

module gpio_controller #(
  // GPIO width, at most XLEN
  parameter int unsigned GW = 32
)(
  input  logic                   clk,
  input  logic                   reset,
  // request
  input  logic                   vld,
  input  degu_bus_pkg::bus_req_t req,
  // registered response
  output degu_bus_pkg::bus_rsp_t rsp,
  // pins
  output logic [GW-1:0]          gpio_o,
  output logic [GW-1:0]          gpio_e,
  input  logic [GW-1:0]          gpio_i
);

  import degu_bus_pkg::*;

  // word offset width inside the GPIO window
  localparam int unsigned OW = GPIO_BIT - BLOG;

  // register word offset
  logic [OW-1:0]   ofs;
  // synchronizer first stage and input register
  logic [GW-1:0]   gpio_s;
  logic [GW-1:0]   gpio_r;
  // read mux and its register
  logic [XLEN-1:0] rmx;
  logic [XLEN-1:0] rdt;

  assign ofs = req.adr[GPIO_BIT-1:BLOG];

////////////////////////////////////////////////////////////////////////////
// output and enable registers
////////////////////////////////////////////////////////////////////////////

  // per bit write, enabled by the byte holding that bit
  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (vld && req.wen) begin
      for (int i = 0; i < GW; i++) begin
        if (req.ben[i/8]) begin
          if (ofs == OW'(GPIO_OUT_OFS)) gpio_o[i] <= req.wdt[i];
          if (ofs == OW'(GPIO_ENA_OFS)) gpio_e[i] <= req.wdt[i];
        end
      end
    end
  end

  // two flop input synchronizer
  always_ff @(posedge clk) begin
    gpio_s <= gpio_i;
    gpio_r <= gpio_s;
  end

////////////////////////////////////////////////////////////////////////////
// read response
////////////////////////////////////////////////////////////////////////////

  // zero extended register select, unused offsets read 0
  always_comb begin
    case (ofs)
      OW'(GPIO_OUT_OFS): rmx = XLEN'(gpio_o);
      OW'(GPIO_ENA_OFS): rmx = XLEN'(gpio_e);
      OW'(GPIO_INP_OFS): rmx = XLEN'(gpio_r);
      default:           rmx = '0;
    endcase
  end

  // stores answer with zero
  always_ff @(posedge clk) begin
    if (vld) rdt <= req.wen ? '0 : rmx;
  end

  assign rsp = '{rdt: rdt, err: 1'b0};

endmodule: gpio_controller

// File: response_combiner.sv
`timescale 1ns/10ps

module response_combiner (
  input  logic                   clk,
  input  logic                   reset,
  // request side
  input  logic                   req_vld,
  input  degu_bus_pkg::tgt_sel_t tgt_sel,
  // target responses
  input  degu_bus_pkg::bus_rsp_t mem_rsp,
  input  degu_bus_pkg::bus_rsp_t gpio_rsp,
  // response to the bus master
  output logic                   rsp_vld,
  output degu_bus_pkg::bus_rsp_t rsp
);

  import degu_bus_pkg::*;

  // select of the request in flight, cleared when idle
  tgt_sel_t sel;

  // one cycle delay matching the targets
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_vld <= 1'b0;
      sel     <= '0;
    end else begin
      rsp_vld <= req_vld;
      sel     <= req_vld ? tgt_sel : '0;
    end
  end

  // response mux
  always_comb begin
    rsp = '0;
    if (sel.mem) begin
      rsp = mem_rsp;
    end else if (sel.gpio) begin
      rsp = gpio_rsp;
    end else if (sel.none) begin
      // unmapped, no data
      rsp.rdt = '0;
      rsp.err = 1'b1;
    end
  end

endmodule: response_combiner

// File: degu_soc_top.sv
`timescale 1ns/10ps

module degu_soc_top #(
  // GPIO width
  parameter int unsigned GW      = 32,
  // data memory word address bits
  parameter int unsigned MEM_ADR = 12
)(
  input  logic                   clk,
  input  logic                   reset,
  // load/store bus
  input  logic                   req_vld,
  input  degu_bus_pkg::bus_req_t req,
  output logic                   rsp_vld,
  output degu_bus_pkg::bus_rsp_t rsp,
  // GPIO pins
  output logic [GW-1:0]          gpio_o,
  output logic [GW-1:0]          gpio_e,
  input  logic [GW-1:0]          gpio_i
);

  import degu_bus_pkg::*;

////////////////////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////////////////////

  tgt_sel_t tgt_sel;
  logic     mem_vld;
  logic     gpio_vld;
  bus_rsp_t mem_rsp;
  bus_rsp_t gpio_rsp;

////////////////////////////////////////////////////////////////////////////
// instances
////////////////////////////////////////////////////////////////////////////

  // memory or GPIO or error
  lsu_decoder dec (.req (req), .req_vld (req_vld), .tgt_sel (tgt_sel),
                   .mem_vld (mem_vld), .gpio_vld (gpio_vld));

  // data memory
  data_memory #(.MEM_ADR (MEM_ADR)) dmem (.clk (clk), .reset (reset),
                   .vld (mem_vld), .req (req), .rsp (mem_rsp));

  // GPIO controller
  gpio_controller #(.GW (GW)) gpio (.clk (clk), .reset (reset),
                   .vld (gpio_vld), .req (req), .rsp (gpio_rsp),
                   .gpio_o (gpio_o), .gpio_e (gpio_e), .gpio_i (gpio_i));

  // response back to the master
  response_combiner cmb (.clk (clk), .reset (reset), .req_vld (req_vld),
                   .tgt_sel (tgt_sel), .mem_rsp (mem_rsp), .gpio_rsp (gpio_rsp),
                   .rsp_vld (rsp_vld), .rsp (rsp));

endmodule: degu_soc_top

// File: degu_soc_chk.sv
`timescale 1ns/10ps

module degu_soc_chk (
  input logic                   clk,
  input logic                   reset,
  input logic                   req_vld,
  input logic                   rsp_vld,
  input degu_bus_pkg::bus_rsp_t rsp
);

  // number of assertion failures so far
  int fails = 0;

////////////////////////////////////////////////////////////////////////////
// bus timing
////////////////////////////////////////////////////////////////////////////

  // fixed one cycle latency
  rsp_follows_req: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> rsp_vld == $past(req_vld))
    else begin
      fails++;
      $error("rsp_vld is not req_vld delayed by one cycle");
    end

  // nothing in flight right after reset
  rsp_idle_after_reset: assert property (@(posedge clk)
    $past(reset) && !reset |-> !rsp_vld)
    else begin
      fails++;
      $error("rsp_vld high in the first cycle after reset");
    end

  // error only on a real response
  err_needs_vld: assert property (@(posedge clk) disable iff (reset)
    rsp.err |-> rsp_vld)
    else begin
      fails++;
      $error("err set without rsp_vld");
    end

endmodule: degu_soc_chk

// File: tb_degu_soc.sv
`timescale 1ns/10ps

module tb_degu_soc;

  import degu_bus_pkg::*;

  // one stimulus line without its name
  typedef struct packed {
    logic            wen;
    logic [XLEN-1:0] adr;
    logic [BLEN-1:0] ben;
    logic [XLEN-1:0] wdt;
    logic [XLEN-1:0] gin;
    logic [XLEN-1:0] ert;
    logic            eer;
    logic [7:0]      idle;
  } vec_t;

  logic            clk;
  logic            reset;
  logic            req_vld;
  bus_req_t        req;
  logic            rsp_vld;
  bus_rsp_t        rsp;
  logic [XLEN-1:0] gpio_o;
  logic [XLEN-1:0] gpio_e;
  logic [XLEN-1:0] gpio_i;

  // vectors and their names
  vec_t            vecs[$];
  string           names[$];
  // response due at the next falling edge
  logic            pend;
  string           pend_name;
  bus_rsp_t        pend_rsp;
  // gpio_i for the next drive and the expected pins
  logic [XLEN-1:0] gin_nxt;
  logic [XLEN-1:0] go_m;
  logic [XLEN-1:0] ge_m;
  // random traffic state and memory model
  logic [31:0]     lfsr;
  logic [XLEN-1:0] model [int];
  logic [XLEN-1:0] adrs[$];
  int              limit = 1000;
  int              cycles;
  int              n_tests;
  int              n_err;

  degu_soc_top uut (.clk (clk), .reset (reset), .req_vld (req_vld), .req (req),
                    .rsp_vld (rsp_vld), .rsp (rsp), .gpio_o (gpio_o),
                    .gpio_e (gpio_e), .gpio_i (gpio_i));

  bind degu_soc_top degu_soc_chk chk (.clk (clk), .reset (reset),
                    .req_vld (req_vld), .rsp_vld (rsp_vld), .rsp (rsp));

  // 40 ns period
  always #20 clk = ~clk;

////////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////////

  // Galois step with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // n bits with one lfsr step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // response of the previous cycle and the pins
  task automatic check_rsp();
    logic ok;
    ok = 1'b1;
    if (pend) begin
      assert (rsp_vld === 1'b1) else begin
        $display("%s: no response one cycle after the request", pend_name);
        ok = 1'b0;
      end
      assert (rsp === pend_rsp) else begin
        $display("Error %s: expected rdt %h err %b, actual rdt %h err %b", pend_name,
                 pend_rsp.rdt, pend_rsp.err, rsp.rdt, rsp.err);
        ok = 1'b0;
      end
      assert (gpio_o === go_m && gpio_e === ge_m) else begin
        $display("Error %s: expected gpio_o %h gpio_e %h, actual gpio_o %h gpio_e %h",
                 pend_name, go_m, ge_m, gpio_o, gpio_e);
        ok = 1'b0;
      end
      n_tests++;
      if (!ok) n_err++;
      $display("%s: %s", pend_name, ok ? "pass" : "FAIL");
    end else begin
      assert (rsp_vld === 1'b0) else begin
        $display("rsp_vld was high with no request in flight");
        n_err++;
      end
    end
  endtask

  // on the falling edge check the last response then drive
  task automatic step(input logic vld, input bus_req_t r, input string nm,
                      input bus_rsp_t e);
    @(negedge clk);
    check_rsp();
    gpio_i    = gin_nxt;
    req_vld   = vld;
    req       = r;
    pend      = vld;
    pend_name = nm;
    pend_rsp  = e;
    // pin model for mapped GPIO stores to offsets 0 and 1
    if (vld && r.wen && r.adr[31:15] == '0 && r.adr[14] && !r.adr[6]) begin
      for (int b = 0; b < 4; b++) begin
        if (r.ben[b] && r.adr[5:2] == 4'd0) go_m[8*b +: 8] = r.wdt[8*b +: 8];
        if (r.ben[b] && r.adr[5:2] == 4'd1) ge_m[8*b +: 8] = r.wdt[8*b +: 8];
      end
    end
  endtask

  task automatic load_vectors(output logic ok);
    int              fd;
    int              n;
    int              idle;
    string           line;
    string           nm;
    logic            wen;
    logic            eer;
    logic [BLEN-1:0] ben;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] wdt;
    logic [XLEN-1:0] gin;
    logic [XLEN-1:0] ert;
    fd = $fopen("degu_soc_stim.txt", "r");
    if (fd == 0) $display("Could not open degu_soc_stim.txt for reading");
    while (fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      // skip comments and blank lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %d",
                    nm, wen, adr, ben, wdt, gin, ert, eer, idle);
        if (n == 9) begin
          vecs.push_back('{wen, adr, ben, wdt, gin, ert, eer, 8'(idle)});
          names.push_back(nm);
        end else begin
          $display("Stimulus line could not be parsed: %s", line);
          n_err++;
        end
      end
    end
    if (fd != 0) $fclose(fd);
    ok = vecs.size() > 0;
  endtask

////////////////////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////////////////////

  initial begin
    logic            ok;
    logic [31:0]     d;
    logic [31:0]     w;
    logic [XLEN-1:0] a;
    bus_req_t        r;
    bus_rsp_t        e;
    clk     = 1'b0;
    reset   = 1'b1;
    // a load held through reset must leave no response behind
    req_vld = 1'b1;
    req     = '0;
    gpio_i  = '0;
    gin_nxt = '0;
    pend    = 1'b0;
    go_m    = '0;
    ge_m    = '0;
    lfsr    = 32'h096736a0;
    n_tests = 0;
    n_err   = 0;
    load_vectors(ok);
    // every line with its idles plus 64 random requests and a margin
    limit = 64 + 50;
    foreach (vecs[i]) limit += 1 + int'(vecs[i].idle);
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset   = 1'b0;
    req_vld = 1'b0;
    if (ok) begin
      // quiet bus after reset
      repeat (2) step(1'b0, '0, "", '0);
      foreach (vecs[i]) begin
        gin_nxt = vecs[i].gin;
        repeat (vecs[i].idle) step(1'b0, '0, "", '0);
        r = '{wen: vecs[i].wen, adr: vecs[i].adr, ben: vecs[i].ben, wdt: vecs[i].wdt};
        e = '{rdt: vecs[i].ert, err: vecs[i].eer};
        step(1'b1, r, names[i], e);
      end
      // back to back stores and then loads
      for (int k = 0; k < 32; k++) begin
        draw_bits(12, d);
        draw_bits(32, w);
        a = {18'd0, d[11:0], 2'b00};
        model[int'(d[11:0])] = w;
        adrs.push_back(a);
        r = '{wen: 1'b1, adr: a, ben: 4'hf, wdt: w};
        step(1'b1, r, $sformatf("rnd_st_%0d", k), '0);
      end
      for (int k = 0; k < 32; k++) begin
        r = '{wen: 1'b0, adr: adrs[k], ben: 4'hf, wdt: '0};
        e = '{rdt: model[int'(adrs[k][13:2])], err: 1'b0};
        step(1'b1, r, $sformatf("rnd_ld_%0d", k), e);
      end
      // collect the last response
      step(1'b0, '0, "", '0);
    end
    // bus timing failures seen by the bound checker
    n_err += uut.chk.fails;
    $display("tests %0d, errors %0d", n_tests, n_err);
    if (ok && n_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // cycle guard
  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule: tb_degu_soc

// File: degu_soc_stim.txt
# name wen addr ben wdata gpio_i exp_rdt exp_err idle_before
# hex fields, idle_before in decimal cycles
rst_ld_out    0 00004000 f 00000000 00000000 00000000 0 0
rst_ld_ena    0 00004004 f 00000000 00000000 00000000 0 0
mem_st_w0     1 00000100 f 11223344 00000000 00000000 0 0
mem_st_w1     1 00000104 f a5a5a5a5 00000000 00000000 0 0
mem_st_w2     1 00000108 f 00000000 00000000 00000000 0 0
mem_st_b1     1 00000100 2 0000ee00 00000000 00000000 0 0
mem_st_h1     1 00000104 c 7788ffff 00000000 00000000 0 0
mem_st_b0     1 00000104 1 000000cc 00000000 00000000 0 0
mem_st_h0     1 00000108 3 ffffbeef 00000000 00000000 0 0
mem_ld_w0     0 00000100 f 00000000 00000000 1122ee44 0 0
mem_ld_w1     0 00000104 f 00000000 00000000 7788a5cc 0 0
mem_ld_w2     0 00000108 f 00000000 00000000 0000beef 0 0
gpio_st_out   1 00004000 f cafe1234 00000000 00000000 0 0
gpio_st_ena   1 00004004 3 ffffffff 00000000 00000000 0 0
gpio_ld_out   0 00004000 f 00000000 00000000 cafe1234 0 0
gpio_ld_ena   0 00004004 f 00000000 00000000 0000ffff 0 0
gpio_st_inp   1 00004008 f 12345678 00000000 00000000 0 0
gpio_st_out_b 1 00004000 8 5a000000 00000000 00000000 0 0
gpio_ld_out_b 0 00004000 f 00000000 00000000 5afe1234 0 0
gpio_ld_inp   0 00004008 f 00000000 89abcdef 89abcdef 0 3
gpio_ld_inp2  0 00004008 f 00000000 00ff00ff 00ff00ff 0 3
gpio_ld_unuse 0 0000400c f 00000000 00000000 00000000 0 0
uart_st       1 00004040 f deadbeef 00000000 00000000 1 0
uart_ld       0 00004048 f 00000000 00000000 00000000 1 0
high_st       1 00010100 f deadbeef 00000000 00000000 1 0
high_ld       0 80000104 f 00000000 00000000 00000000 1 0
mem_ld_keep   0 00000100 f 00000000 00000000 1122ee44 0 0

// File: src.f
degu_bus_pkg.sv
lsu_decoder.sv
data_memory.sv
gpio_controller.sv
response_combiner.sv
degu_soc_top.sv
degu_soc_chk.sv
tb_degu_soc.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_degu_soc \
  -f src.f \
  -o tb_degu_soc

./obj_dir/tb_degu_soc | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
